/* Makefile */
VERILATOR  ?= verilator
TOP        ?= gdiv_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
VFLAGS     ?=

SOURCES := $(wildcard hdl/*.sv dv/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing --assert \
		-f $(FILELIST) --top-module $(TOP) $(VFLAGS)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert \
		-f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) $(VFLAGS)

sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* dv/gdiv_tb.sv */
`timescale 1ns/1ps

module gdiv_tb;

   localparam int FRAC_W   = 23;
   localparam int IDX_W    = 8;
   localparam int ITERS    = 3;
   localparam int DONE_LAT = 2 * ITERS + 4;
   localparam int N_RAND   = 200;
   // Corner cases, random pairs, latency run, refused divisor, two for done clearing
   localparam int N_DIV      = 5 + N_RAND + 4;
   localparam int MAX_CYCLES = 40 * N_DIV + 200;

   logic                       clk;
   logic                       rst_n;
   logic                       cyc;
   logic                       stb;
   logic                       we;
   logic [gdiv_pkg::WB_AW-1:0] adr;
   logic [gdiv_pkg::WB_DW-1:0] dat_w;
   logic [3:0]                 sel;
   logic [gdiv_pkg::WB_DW-1:0] dat_r;
   logic                       ack;
   int                         seed;
   int                         cycles;

   gdiv_top #(
      .FRAC_W (FRAC_W),
      .IDX_W  (IDX_W),
      .ITERS  (ITERS)
   ) dut (
      .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .sel, .dat_r, .ack
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic expect_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      a_value: assert (act === exp) else
         report_failure($sformatf("mismatch %s expected 0x%08h actual 0x%08h",
                                  name, exp, act));
   endtask

   // Holds the request through the ack cycle, then releases the bus
   task automatic write_reg(input gdiv_pkg::gdiv_reg_e a, input logic [31:0] d);
      int waited;
      @(posedge clk);
      #2;
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = 1'b1;
      adr   = a;
      dat_w = d;
      sel   = 4'hf;
      waited = 0;
      do begin
         @(posedge clk);
         #2;
         waited++;
      end while (!ack && waited < 4);
      if (!ack) begin
         report_failure("the slave never acknowledged a write");
      end
      @(posedge clk);
      #2;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic read_reg(input gdiv_pkg::gdiv_reg_e a, output logic [31:0] d);
      int waited;
      @(posedge clk);
      #2;
      cyc = 1'b1;
      stb = 1'b1;
      we  = 1'b0;
      adr = a;
      sel = 4'hf;
      waited = 0;
      do begin
         @(posedge clk);
         #2;
         waited++;
      end while (!ack && waited < 4);
      if (!ack) begin
         report_failure("the slave never acknowledged a read");
      end
      d = dat_r;
      @(posedge clk);
      #2;
      cyc = 1'b0;
      stb = 1'b0;
   endtask

   task automatic poll_done(output logic [31:0] status);
      int polls;
      polls = 0;
      read_reg(gdiv_pkg::REG_STATUS, status);
      while (!status[1] && polls < 2 * DONE_LAT) begin
         read_reg(gdiv_pkg::REG_STATUS, status);
         polls++;
      end
      a_done_seen: assert (status[1]) else
         report_failure("done never showed up in the status register");
   endtask

   // floor(a * 2^FRAC_W / b) in plain integer arithmetic
   function automatic logic [31:0] model_quotient(input logic [31:0] a,
                                                  input logic [31:0] b);
      longint unsigned num;
      longint unsigned den;
      num = {32'd0, a};
      num = num << FRAC_W;
      den = {32'd0, b};
      return 32'(num / den);
   endfunction

   function automatic logic [31:0] random_mantissa();
      logic [31:0] r;
      r = $random(seed);
      return {{(31 - FRAC_W){1'b0}}, 1'b1, r[FRAC_W-1:0]};
   endfunction

   task automatic divide_and_check(input string name, input logic [31:0] a,
                                   input logic [31:0] b);
      logic [31:0] status;
      logic [31:0] quot;
      write_reg(gdiv_pkg::REG_DIVIDEND, a);
      write_reg(gdiv_pkg::REG_DIVISOR, b);
      write_reg(gdiv_pkg::REG_CTRL, 32'd1);
      poll_done(status);
      expect_value({name, " status"}, 32'd2, status);
      read_reg(gdiv_pkg::REG_QUOTIENT, quot);
      expect_value(name, model_quotient(a, b), quot);
   endtask

   // Second start lands while the engine is still running
   task automatic check_latency();
      logic [31:0] status;
      logic [31:0] quot;
      write_reg(gdiv_pkg::REG_DIVIDEND, 32'h00F0_1234);
      write_reg(gdiv_pkg::REG_DIVISOR, 32'h0091_ABCD);
      write_reg(gdiv_pkg::REG_CTRL, 32'd1);
      write_reg(gdiv_pkg::REG_CTRL, 32'd1);
      read_reg(gdiv_pkg::REG_STATUS, status);
      expect_value("status while busy", 32'd1, status);
      poll_done(status);
      read_reg(gdiv_pkg::REG_QUOTIENT, quot);
      expect_value("start while busy", model_quotient(32'h00F0_1234, 32'h0091_ABCD), quot);
   endtask

   task automatic check_refused();
      logic [31:0] status;
      logic [31:0] quot;
      write_reg(gdiv_pkg::REG_DIVIDEND, 32'h0080_0000);
      write_reg(gdiv_pkg::REG_DIVISOR, 32'h007F_FFFF);
      write_reg(gdiv_pkg::REG_CTRL, 32'd1);
      poll_done(status);
      expect_value("refused divisor status", 32'd6, status);
      read_reg(gdiv_pkg::REG_QUOTIENT, quot);
      expect_value("refused divisor quotient", 32'd0, quot);
   endtask

   task automatic check_done_clear();
      logic [31:0] status;
      divide_and_check("before operand write", 32'h00C3_5000, 32'h00A1_0101);
      write_reg(gdiv_pkg::REG_DIVIDEND, 32'h00D0_0000);
      read_reg(gdiv_pkg::REG_STATUS, status);
      expect_value("status after dividend write", 32'd0, status);
      write_reg(gdiv_pkg::REG_DIVISOR, 32'h0088_8888);
      read_reg(gdiv_pkg::REG_STATUS, status);
      expect_value("status after divisor write", 32'd0, status);
      divide_and_check("after operand write", 32'h00D0_0000, 32'h0088_8888);
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         report_failure("timeout, the run took too many cycles");
      end
   end

   a_ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      ack |=> !ack) else report_failure("ack stayed high longer than one cycle");

   a_ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
      (cyc && stb && !ack) |=> ack) else report_failure("ack missed its cycle");

   a_ack_has_req: assert property (@(posedge clk) disable iff (!rst_n)
      ack |-> $past(cyc && stb)) else report_failure("ack without a request");

   a_busy_done: assert property (@(posedge clk) disable iff (!rst_n)
      !(dut.busy && dut.u_regs.done)) else report_failure("busy and done both set");

   // Normal division, counted from the edge that closes the start ack
   a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
      dut.start |=> dut.busy) else report_failure("busy did not rise after start");

   a_busy_end: assert property (@(posedge clk) disable iff (!rst_n)
      (dut.start && dut.req.divisor[FRAC_W]) |-> ##(DONE_LAT) dut.busy ##1 !dut.busy)
      else report_failure("busy did not last for the whole division");

   a_done_early: assert property (@(posedge clk) disable iff (!rst_n)
      (dut.start && dut.req.divisor[FRAC_W]) |-> ##(DONE_LAT + 1) !dut.u_regs.done)
      else report_failure("done was set too early");

   a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
      (dut.start && dut.req.divisor[FRAC_W]) |-> ##(DONE_LAT + 2) dut.u_regs.done)
      else report_failure("done was not set on time");

   a_err_latency: assert property (@(posedge clk) disable iff (!rst_n)
      (dut.start && !dut.req.divisor[FRAC_W]) |-> ##3
         (dut.u_regs.done && dut.u_regs.result.div_err))
      else report_failure("refused divisor did not set done and div_err");

   a_done_clear: assert property (@(posedge clk) disable iff (!rst_n)
      (ack && we && !dut.busy && (adr == gdiv_pkg::REG_DIVIDEND ||
                                 adr == gdiv_pkg::REG_DIVISOR)) |=> !dut.u_regs.done)
      else report_failure("an operand write left done set");

   a_start_ignored: assert property (@(posedge clk) disable iff (!rst_n)
      (ack && we && adr == gdiv_pkg::REG_CTRL && dat_w[0] && dut.busy) |-> !dut.start)
      else report_failure("a start while busy was accepted");

   initial begin
      logic [31:0] status;
      logic [31:0] a;
      logic [31:0] b;
      cyc    = 1'b0;
      stb    = 1'b0;
      we     = 1'b0;
      adr    = '0;
      dat_w  = '0;
      sel    = '0;
      rst_n  = 1'b0;
      cycles = 0;
      seed   = 32'h7a3;
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;
      a_reset_ack: assert (ack === 1'b0) else report_failure("ack is not low after reset");
      read_reg(gdiv_pkg::REG_STATUS, status);
      expect_value("status after reset", 32'd0, status);
      // Corner operands
      divide_and_check("equal operands", 32'h00C0_0000, 32'h00C0_0000);
      divide_and_check("one by nearly two", 32'h0080_0000, 32'h00FF_FFFF);
      divide_and_check("nearly two by one", 32'h00FF_FFFF, 32'h0080_0000);
      divide_and_check("same leading bits", 32'h009A_5F01, 32'h009A_5FFE);
      divide_and_check("one by one", 32'h0080_0000, 32'h0080_0000);
      for (int i = 0; i < N_RAND; i++) begin
         a = random_mantissa();
         b = random_mantissa();
         divide_and_check($sformatf("random pair %0d", i), a, b);
      end
      check_latency();
      check_refused();
      check_done_clear();
      $display("All tests passed");
      $finish;
   end

endmodule

/* filelist.f */
hdl/gdiv_pkg.sv
hdl/gdiv_wb_regs.sv
hdl/gdiv_recip_table.sv
hdl/gdiv_ctrl.sv
hdl/gdiv_datapath.sv
hdl/gdiv_round.sv
hdl/gdiv_top.sv
dv/gdiv_tb.sv

/* hdl/gdiv_ctrl.sv */
`timescale 1ns/1ps

module gdiv_ctrl #(
   parameter int FRAC_W = 23,
   parameter int ITERS  = 3
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   start,
   input  gdiv_pkg::gdiv_req_t    req,
   output logic                   busy,
   output gdiv_pkg::gdiv_dp_ctrl_t dp_ctrl,
   output logic                   take,
   output logic                   div_err
);

   localparam int CNT_W = (ITERS > 1) ? $clog2(ITERS) : 1;

   gdiv_pkg::gdiv_state_e state;
   logic [CNT_W-1:0]      iter_cnt;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= gdiv_pkg::IDLE;
         iter_cnt <= '0;
         div_err  <= 1'b0;
      end else begin
         case (state)
            gdiv_pkg::IDLE: begin
               iter_cnt <= '0;
               if (start) begin
                  // Unnormalized divisor goes straight to the result stage
                  div_err <= !req.divisor[FRAC_W];
                  state   <= req.divisor[FRAC_W] ? gdiv_pkg::SEED : gdiv_pkg::SELECT;
               end
            end
            gdiv_pkg::SEED:   state <= gdiv_pkg::ITER_N;
            gdiv_pkg::ITER_N: state <= gdiv_pkg::ITER_D;
            gdiv_pkg::ITER_D: begin
               if (iter_cnt == CNT_W'(ITERS - 1)) begin
                  state <= gdiv_pkg::QUOT;
               end else begin
                  iter_cnt <= iter_cnt + 1'b1;
                  state    <= gdiv_pkg::ITER_N;
               end
            end
            gdiv_pkg::QUOT:   state <= gdiv_pkg::REM;
            gdiv_pkg::REM:    state <= gdiv_pkg::SELECT;
            default:          state <= gdiv_pkg::IDLE;
         endcase
      end
   end

   assign busy = (state != gdiv_pkg::IDLE);
   assign take = (state == gdiv_pkg::SELECT);

   // One multiplier pass per state
   always_comb begin
      dp_ctrl       = '0;
      dp_ctrl.opsel = gdiv_pkg::OPS_N_K;
      case (state)
         gdiv_pkg::SEED: begin
            dp_ctrl.opsel  = gdiv_pkg::OPS_SEED;
            dp_ctrl.load_k = 1'b1;
         end
         gdiv_pkg::ITER_N: dp_ctrl.load_n = 1'b1;
         gdiv_pkg::ITER_D: begin
            dp_ctrl.opsel  = gdiv_pkg::OPS_D_K;
            dp_ctrl.load_d = 1'b1;
         end
         gdiv_pkg::QUOT:   dp_ctrl.load_q = 1'b1;
         gdiv_pkg::REM: begin
            dp_ctrl.opsel  = gdiv_pkg::OPS_Q_D;
            dp_ctrl.load_r = 1'b1;
         end
         default: ;
      endcase
   end

   a_load_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({dp_ctrl.load_n, dp_ctrl.load_d, dp_ctrl.load_k,
                dp_ctrl.load_q, dp_ctrl.load_r}));

endmodule

/* hdl/gdiv_datapath.sv */
`timescale 1ns/1ps

module gdiv_datapath #(
   parameter int FRAC_W = 23,
   parameter int IDX_W  = 8,
   parameter int ITERS  = 3
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  gdiv_pkg::gdiv_req_t        req,
   input  gdiv_pkg::gdiv_dp_ctrl_t    dp_ctrl,
   output logic [gdiv_pkg::WB_DW-1:0] q_trunc,
   output logic signed [FRAC_W+2:0]   remainder
);

   // Two integer bits, IF fraction bits
   localparam int W  = 2 * FRAC_W + 4;
   localparam int IF = W - 2;

   logic [IDX_W+1:0]  seed;
   logic [W-1:0]      seed_w;
   logic [W-1:0]      dividend_w;
   logic [W-1:0]      divisor_w;
   logic [W-1:0]      n_q;
   logic [W-1:0]      d_q;
   logic [W-1:0]      k_q;
   logic [W-1:0]      mcand;
   logic [W-1:0]      mplier;
   logic [2*W-1:0]    prod;
   logic [W-1:0]      prod_fx;
   logic [W-1:0]      two_minus;
   logic [W-1:0]      rem_wide;
   logic [FRAC_W:0]   q_next;

   gdiv_recip_table #(
      .FRAC_W (FRAC_W),
      .IDX_W  (IDX_W)
   ) u_recip (
      .divisor (req.divisor),
      .seed    (seed)
   );

   // Align operands and seed to the internal fixed point format
   assign dividend_w = {1'b0, req.dividend[FRAC_W:0], {(IF-FRAC_W){1'b0}}};
   assign divisor_w  = {1'b0, req.divisor[FRAC_W:0], {(IF-FRAC_W){1'b0}}};
   assign seed_w     = {1'b0, seed, {(IF-IDX_W-1){1'b0}}};

   always_comb begin
      case (dp_ctrl.opsel)
         gdiv_pkg::OPS_SEED: begin
            mcand  = dividend_w;
            mplier = seed_w;
         end
         gdiv_pkg::OPS_N_K: begin
            mcand  = n_q;
            mplier = k_q;
         end
         gdiv_pkg::OPS_D_K: begin
            mcand  = d_q;
            mplier = k_q;
         end
         default: begin
            // Integer product for the remainder pass
            mcand  = W'(q_trunc[FRAC_W+1:0]);
            mplier = W'(req.divisor[FRAC_W:0]);
         end
      endcase
   end

   assign prod    = mcand * mplier;
   assign prod_fx = prod[IF+W-1:IF];

   // Ones' complement of the new D gives 2-D less one ulp
   assign two_minus = {1'b0, ~prod_fx[W-2:0]};

   // Truncated quotient with FRAC_W fraction bits
   assign q_next = n_q[IF -: FRAC_W+1];

   assign rem_wide = W'({req.dividend[FRAC_W:0], {FRAC_W{1'b0}}}) - prod[W-1:0];

   always_ff @(posedge clk) begin
      if (dp_ctrl.load_k) begin
         n_q <= dividend_w;
         d_q <= divisor_w;
      end
      if (dp_ctrl.load_n) begin
         n_q <= prod_fx;
      end
      if (dp_ctrl.load_d) begin
         d_q <= prod_fx;
      end
      if (dp_ctrl.load_k) begin
         k_q <= seed_w;
      end else if (dp_ctrl.load_d) begin
         k_q <= two_minus;
      end
      if (dp_ctrl.load_q) begin
         q_trunc <= gdiv_pkg::WB_DW'(q_next);
      end
      if (dp_ctrl.load_r) begin
         remainder <= rem_wide[FRAC_W+2:0];
      end
   end

   a_cfg: assert property (@(posedge clk) disable iff (!rst_n)
      FRAC_W <= gdiv_pkg::FRAC_W_MAX && ITERS >= 1);

endmodule

/* hdl/gdiv_pkg.sv */
package gdiv_pkg;

   // Bus geometry
   localparam int WB_DW = 32;
   localparam int WB_AW = 3;

   // Quotient of FRAC_W+1 bits plus carry headroom must fit a bus word
   localparam int FRAC_W_MAX = 29;

   typedef enum logic [WB_AW-1:0] {
      REG_DIVIDEND = 3'd0,
      REG_DIVISOR  = 3'd1,
      REG_CTRL     = 3'd2,
      REG_STATUS   = 3'd3,
      REG_QUOTIENT = 3'd4
   } gdiv_reg_e;

   typedef enum logic [2:0] {
      IDLE,
      SEED,
      ITER_N,
      ITER_D,
      QUOT,
      REM,
      SELECT
   } gdiv_state_e;

   // Operand pairing at the shared multiplier
   typedef enum logic [1:0] {
      OPS_SEED,
      OPS_N_K,
      OPS_D_K,
      OPS_Q_D
   } gdiv_opsel_e;

   typedef struct packed {
      logic [WB_DW-1:0] dividend;
      logic [WB_DW-1:0] divisor;
   } gdiv_req_t;

   typedef struct packed {
      gdiv_opsel_e opsel;
      logic        load_n;
      logic        load_d;
      logic        load_k;
      logic        load_q;
      logic        load_r;
   } gdiv_dp_ctrl_t;

   typedef struct packed {
      logic [WB_DW-1:0] quotient;
      logic             div_err;
   } gdiv_rsp_t;

endpackage

/* hdl/gdiv_recip_table.sv */
`timescale 1ns/1ps

module gdiv_recip_table #(
   parameter int FRAC_W = 23,
   parameter int IDX_W  = 8
) (
   input  logic [gdiv_pkg::WB_DW-1:0] divisor,
   output logic [IDX_W+1:0]          seed
);

   logic [IDX_W+1:0] rom [2**IDX_W];
   logic [IDX_W-1:0] idx;

   // Rounded 1/m, m the interval midpoint, IDX_W+1 fraction bits
   function automatic logic [IDX_W+1:0] seed_calc(input int unsigned i);
      longint unsigned den;
      longint unsigned num;
      den = (64'd1 << (IDX_W + 1)) + 2 * i + 1;
      num = 64'd1 << (2 * IDX_W + 2);
      return (IDX_W+2)'((num + den / 2) / den);
   endfunction

   for (genvar i = 0; i < 2**IDX_W; i++) begin : g_rom
      assign rom[i] = seed_calc(i);
   end

   // Leading fraction bits below the hidden one
   assign idx  = divisor[FRAC_W-1 -: IDX_W];
   assign seed = rom[idx];

endmodule

/* hdl/gdiv_round.sv */
`timescale 1ns/1ps

module gdiv_round #(
   parameter int FRAC_W = 23
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       take,
   input  logic                       div_err,
   input  logic [gdiv_pkg::WB_DW-1:0] q_trunc,
   input  logic signed [FRAC_W+2:0]   remainder,
   input  gdiv_pkg::gdiv_req_t        req,
   output gdiv_pkg::gdiv_rsp_t        rsp,
   output logic                       finish
);

   logic signed [FRAC_W+2:0]   divisor_s;
   logic [gdiv_pkg::WB_DW-1:0] q_sel;

   assign divisor_s = $signed({2'b00, req.divisor[FRAC_W:0]});

   // Pick among q-1, q and q+1 from the remainder
   always_comb begin
      if (div_err) begin
         q_sel = '0;
      end else if (remainder < 0) begin
         q_sel = q_trunc - 1'b1;
      end else if (remainder >= divisor_s) begin
         q_sel = q_trunc + 1'b1;
      end else begin
         q_sel = q_trunc;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsp    <= '0;
         finish <= 1'b0;
      end else begin
         finish <= take;
         if (take) begin
            rsp.quotient <= q_sel;
            rsp.div_err  <= div_err;
         end
      end
   end

   a_finish_take: assert property (@(posedge clk) disable iff (!rst_n)
      finish |-> $past(take));

endmodule

/* hdl/gdiv_top.sv */
`timescale 1ns/1ps

module gdiv_top #(
   parameter int FRAC_W = 23,
   parameter int IDX_W  = 8,
   parameter int ITERS  = 3
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       cyc,
   input  logic                       stb,
   input  logic                       we,
   input  logic [gdiv_pkg::WB_AW-1:0] adr,
   input  logic [gdiv_pkg::WB_DW-1:0] dat_w,
   input  logic [3:0]                 sel,
   output logic [gdiv_pkg::WB_DW-1:0] dat_r,
   output logic                       ack
);

   logic                       start;
   logic                       busy;
   logic                       take;
   logic                       div_err;
   logic                       finish;
   logic [gdiv_pkg::WB_DW-1:0] q_trunc;
   logic signed [FRAC_W+2:0]   remainder;
   gdiv_pkg::gdiv_req_t        req;
   gdiv_pkg::gdiv_rsp_t        rsp;
   gdiv_pkg::gdiv_dp_ctrl_t    dp_ctrl;

   gdiv_wb_regs u_regs (
      .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .sel,
      .busy, .finish, .rsp, .dat_r, .ack, .start, .req
   );

   gdiv_ctrl #(
      .FRAC_W (FRAC_W),
      .ITERS  (ITERS)
   ) u_ctrl (
      .clk, .rst_n, .start, .req, .busy, .dp_ctrl, .take, .div_err
   );

   gdiv_datapath #(
      .FRAC_W (FRAC_W),
      .IDX_W  (IDX_W),
      .ITERS  (ITERS)
   ) u_dp (
      .clk, .rst_n, .req, .dp_ctrl, .q_trunc, .remainder
   );

   gdiv_round #(
      .FRAC_W (FRAC_W)
   ) u_round (
      .clk, .rst_n, .take, .div_err, .q_trunc, .remainder, .req, .rsp, .finish
   );

endmodule

/* hdl/gdiv_wb_regs.sv */
`timescale 1ns/1ps

module gdiv_wb_regs (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      cyc,
   input  logic                      stb,
   input  logic                      we,
   input  logic [gdiv_pkg::WB_AW-1:0] adr,
   input  logic [gdiv_pkg::WB_DW-1:0] dat_w,
   input  logic [3:0]                sel,
   input  logic                      busy,
   input  logic                      finish,
   input  gdiv_pkg::gdiv_rsp_t       rsp,
   output logic [gdiv_pkg::WB_DW-1:0] dat_r,
   output logic                      ack,
   output logic                      start,
   output gdiv_pkg::gdiv_req_t       req
);

   logic                      done;
   gdiv_pkg::gdiv_rsp_t       result;
   gdiv_pkg::gdiv_reg_e       reg_adr;
   logic                      wr;
   logic [gdiv_pkg::WB_DW-1:0] rd_data;

   // Byte lane merge for partial writes
   function automatic logic [gdiv_pkg::WB_DW-1:0] merge_lanes(
      input logic [gdiv_pkg::WB_DW-1:0] old_val,
      input logic [gdiv_pkg::WB_DW-1:0] new_val,
      input logic [3:0]                 lanes
   );
      logic [gdiv_pkg::WB_DW-1:0] res;
      res = old_val;
      for (int b = 0; b < 4; b++) begin
         if (lanes[b]) begin
            res[8*b +: 8] = new_val[8*b +: 8];
         end
      end
      return res;
   endfunction

   assign reg_adr = gdiv_pkg::gdiv_reg_e'(adr);
   // Writes land in the ack cycle
   assign wr      = ack && we;
   assign start   = wr && (reg_adr == gdiv_pkg::REG_CTRL) && sel[0] && dat_w[0] && !busy;

   always_comb begin
      case (reg_adr)
         gdiv_pkg::REG_DIVIDEND: rd_data = req.dividend;
         gdiv_pkg::REG_DIVISOR:  rd_data = req.divisor;
         gdiv_pkg::REG_STATUS:   rd_data = {29'd0, result.div_err, done, busy};
         gdiv_pkg::REG_QUOTIENT: rd_data = result.quotient;
         default:                rd_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack <= 1'b0;
      end else begin
         ack <= cyc && stb && !ack;
      end
   end

   // Read data captured while the request waits for ack
   always_ff @(posedge clk) begin
      if (cyc && stb && !ack) begin
         dat_r <= rd_data;
      end
   end

   // Operands are frozen while the engine runs
   always_ff @(posedge clk) begin
      if (wr && !busy && reg_adr == gdiv_pkg::REG_DIVIDEND) begin
         req.dividend <= merge_lanes(req.dividend, dat_w, sel);
      end
      if (wr && !busy && reg_adr == gdiv_pkg::REG_DIVISOR) begin
         req.divisor <= merge_lanes(req.divisor, dat_w, sel);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         done   <= 1'b0;
         result <= '0;
      end else begin
         if (finish) begin
            done   <= 1'b1;
            result <= rsp;
         end else if (start) begin
            done <= 1'b0;
         end else if (wr && !busy && (reg_adr == gdiv_pkg::REG_DIVIDEND ||
                                      reg_adr == gdiv_pkg::REG_DIVISOR)) begin
            done <= 1'b0;
         end
      end
   end

   a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ack) |-> $past(cyc && stb));

endmodule
